// File: Makefile
VERILATOR ?= verilator
TOP       ?= copper_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q -F '** FAIL **' $(LOG) || ! grep -q -F '** PASS **' $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/copper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper sequencer
// op fetch, decode and execute FSM
// raster waits and register writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module copper import copper_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        enable,
    input  raster_x_t  raster_x,
    input  raster_y_t  raster_y,
    output logic       read_req,
    output prog_addr_t read_addr,
    input  word_t      read_data,
    output reg_wr_t    reg_wr
);

    typedef enum logic [1:0] {
        st_prefetch,
        st_decode,
        st_data_fetch,
        st_raster_wait
    } state_t;

    state_t       state;
    state_t       state_next;
    prog_addr_t   pc;
    prog_addr_t   pc_next;
    copper_insn_u insn;
    op_t          op;

    raster_x_t target_x;
    raster_y_t target_y;
    raster_y_t next_line;
    logic      target_hit;
    logic      batch_wait;

    // latched write_reg fields
    reg_addr_t  wr_target_reg;
    logic [1:0] wr_inc_mode;
    logic       wr_auto_wait;
    logic [4:0] wr_batches;
    logic [1:0] wr_count;
    logic [1:0] wr_offset;
    logic       batch_done;

    logic      wr_en_q;
    reg_addr_t wr_addr_q;
    word_t     wr_data_q;

    assign insn = read_data;
    // op sits in the same bits of every format
    assign op   = insn.tgt.op;

    assign target_hit = (raster_x == target_x) && (raster_y == target_y);
    assign next_line  = (raster_y == raster_y_t'(raster_h - 1)) ? '0 : raster_y + 1'b1;

    // batch size 1, 2 or 4
    always_comb begin
        case (wr_inc_mode)
            2'd1: begin
                wr_offset  = wr_count & 2'b01;
                batch_done = wr_count[0];
            end
            2'd2: begin
                wr_offset  = wr_count;
                batch_done = (wr_count == 2'b11);
            end
            default: begin
                wr_offset  = 2'b00;
                batch_done = 1'b1;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        pc_next    = pc;
        if (!enable) begin
            state_next = st_prefetch;
            pc_next    = '0;
        end else begin
            case (state)
                st_prefetch: state_next = st_decode;
                st_decode: begin
                    case (op)
                        op_set_target: begin
                            pc_next    = pc + 1'b1;
                            state_next = insn.tgt.wait_en ? st_raster_wait : st_decode;
                        end
                        op_write_reg: begin
                            pc_next    = pc + 1'b1;
                            state_next = st_data_fetch;
                        end
                        op_jump: begin
                            pc_next    = insn.jmp.target;
                            state_next = st_prefetch;
                        end
                        default: pc_next = pc + 1'b1;
                    endcase
                end
                st_data_fetch: begin
                    pc_next = pc + 1'b1;
                    if (batch_done && wr_batches == '0) begin
                        state_next = st_decode;
                    end else if (batch_done && wr_auto_wait) begin
                        state_next = st_raster_wait;
                    end
                end
                default: begin
                    // pc already points at the word to read after the wait
                    if (target_hit) begin
                        state_next = batch_wait ? st_data_fetch : st_decode;
                    end
                end
            endcase
        end
    end

    // only fetch when the next state consumes a word
    assign read_req  = (state_next == st_decode) || (state_next == st_data_fetch);
    assign read_addr = pc_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_prefetch;
            pc         <= '0;
            target_x   <= '0;
            target_y   <= '0;
            batch_wait <= 1'b0;
            wr_batches <= '0;
            wr_count   <= '0;
            wr_en_q    <= 1'b0;
        end else begin
            state   <= state_next;
            pc      <= pc_next;
            wr_en_q <= 1'b0;
            if (!enable) begin
                target_x <= '0;
                target_y <= '0;
            end else if (state == st_decode) begin
                case (op)
                    op_set_target: begin
                        batch_wait <= 1'b0;
                        if (insn.tgt.select_y) begin
                            target_y <= insn.tgt.value[9:0];
                        end else begin
                            target_x <= insn.tgt.value;
                        end
                    end
                    op_write_compressed: begin
                        wr_en_q <= 1'b1;
                        if (insn.cmp.auto_inc_y) begin
                            target_y <= next_line;
                        end
                    end
                    op_write_reg: begin
                        wr_count   <= '0;
                        wr_batches <= insn.wr.batch_count;
                    end
                    default: ;
                endcase
            end else if (state == st_data_fetch) begin
                wr_en_q  <= 1'b1;
                wr_count <= wr_count + 1'b1;
                if (batch_done && wr_batches != '0) begin
                    wr_batches <= wr_batches - 1'b1;
                    if (wr_auto_wait) begin
                        target_y   <= next_line;
                        batch_wait <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode && op == op_write_compressed) begin
            wr_addr_q <= insn.cmp.target_reg[4:0];
            wr_data_q <= word_t'(insn.cmp.data);
        end else if (state == st_data_fetch) begin
            wr_addr_q <= wr_target_reg + reg_addr_t'(wr_offset);
            wr_data_q <= read_data;
        end
        if (state == st_decode && op == op_write_reg) begin
            wr_target_reg <= insn.wr.target_reg;
            wr_inc_mode   <= insn.wr.inc_mode;
            wr_auto_wait  <= insn.wr.auto_wait;
        end
    end

    assign reg_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    // increment mode 3 is reserved
    a_no_inc_mode_3: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_decode && op == op_write_reg && enable) |=> (wr_inc_mode != 2'd3));

    a_no_write_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |=> !reg_wr.en);

endmodule

`default_nettype wire

// File: rtl/copper_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper shared definitions
// raster sizes, widths, op codes
// instruction formats and bus structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package copper_pkg;

    // tiny raster for short simulations
    localparam int raster_w = 20;
    localparam int raster_h = 12;

    localparam int prog_depth   = 2048;
    localparam int host_credits = 2;
    localparam int host_ptr_w   = $clog2(host_credits);
    localparam int reg_count    = 32;

    typedef logic [10:0] raster_x_t;
    typedef logic [9:0]  raster_y_t;
    typedef logic [10:0] prog_addr_t;
    typedef logic [15:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [1:0] {
        op_set_target       = 2'd0,
        op_write_compressed = 2'd1,
        op_write_reg        = 2'd2,
        op_jump             = 2'd3
    } op_t;

    // oo-wsvvv vvvvvvvv
    typedef struct packed {
        op_t         op;
        logic        spare;
        logic        wait_en;
        logic        select_y;
        logic [10:0] value;
    } target_fmt_t;

    // ooiiynnn nn-rrrrr
    typedef struct packed {
        op_t       op;
        logic [1:0] inc_mode;
        logic       auto_wait;
        logic [4:0] batch_count;
        logic       spare;
        reg_addr_t  target_reg;
    } write_fmt_t;

    // oo--yddd ddrrrrrr
    typedef struct packed {
        op_t        op;
        logic [1:0] spare;
        logic       auto_inc_y;
        logic [4:0] data;
        logic [5:0] target_reg;
    } compressed_fmt_t;

    // oo---ttt tttttttt
    typedef struct packed {
        op_t        op;
        logic [2:0] spare;
        prog_addr_t target;
    } jump_fmt_t;

    typedef union packed {
        target_fmt_t     tgt;
        write_fmt_t      wr;
        compressed_fmt_t cmp;
        jump_fmt_t       jmp;
        word_t           raw;
    } copper_insn_u;

    typedef struct packed {
        logic       en;
        prog_addr_t addr;
        word_t      data;
    } host_wr_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: rtl/copper_program_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper program memory
// host write buffer, copper-first
// arbiter and credit return
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module copper_program_mem import copper_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        read_req,
    input  prog_addr_t read_addr,
    output word_t      read_data,
    input  host_wr_t   host_wr,
    output logic       host_credit
);

    word_t mem [prog_depth];

    // pending host writes, oldest at wb_rd
    prog_addr_t wb_addr [host_credits];
    word_t      wb_data [host_credits];

    logic [host_ptr_w-1:0] wb_rd;
    logic [host_ptr_w-1:0] wb_wr;
    logic [host_ptr_w:0]   wb_count;
    logic                  commit;

    // copper always wins the port
    assign commit = (wb_count != '0) && !read_req;

    always_ff @(posedge clk) begin
        if (read_req) begin
            read_data <= mem[read_addr];
        end else if (commit) begin
            mem[wb_addr[wb_rd]] <= wb_data[wb_rd];
        end
    end

    always_ff @(posedge clk) begin
        if (host_wr.en) begin
            wb_addr[wb_wr] <= host_wr.addr;
            wb_data[wb_wr] <= host_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_rd       <= '0;
            wb_wr       <= '0;
            wb_count    <= '0;
            host_credit <= 1'b0;
        end else begin
            host_credit <= commit;
            if (host_wr.en) begin
                wb_wr <= (wb_wr == host_ptr_w'(host_credits - 1)) ? '0 : wb_wr + 1'b1;
            end
            if (commit) begin
                wb_rd <= (wb_rd == host_ptr_w'(host_credits - 1)) ? '0 : wb_rd + 1'b1;
            end
            wb_count <= wb_count + host_wr.en - commit;
        end
    end

    // a full buffer means the host wrote without holding a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        host_wr.en |-> (wb_count != (host_ptr_w + 1)'(host_credits)) || commit);

endmodule

`default_nettype wire

// File: rtl/copper_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper top level
// timer, copper, program memory
// and display registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module copper_top import copper_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       enable,
    input  host_wr_t  host_wr,
    input  reg_addr_t reg_rd_addr,
    output logic      host_credit,
    output reg_wr_t   reg_wr,
    output word_t     reg_rd_data,
    output raster_x_t raster_x,
    output raster_y_t raster_y
);

    logic       read_req;
    prog_addr_t read_addr;
    word_t      read_data;

    raster_timer i_raster_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .raster_x (raster_x),
        .raster_y (raster_y)
    );

    copper i_copper (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .raster_x  (raster_x),
        .raster_y  (raster_y),
        .read_req  (read_req),
        .read_addr (read_addr),
        .read_data (read_data),
        .reg_wr    (reg_wr)
    );

    copper_program_mem i_copper_program_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_req    (read_req),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .host_wr     (host_wr),
        .host_credit (host_credit)
    );

    vdp_reg_file i_vdp_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .reg_rd_addr (reg_rd_addr),
        .reg_rd_data (reg_rd_data)
    );

endmodule

`default_nettype wire

// File: rtl/raster_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster position counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module raster_timer import copper_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    output raster_x_t raster_x,
    output raster_y_t raster_y
);

    logic x_wrap;
    logic y_wrap;

    assign x_wrap = (raster_x == raster_x_t'(raster_w - 1));
    assign y_wrap = (raster_y == raster_y_t'(raster_h - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raster_x <= '0;
            raster_y <= '0;
        end else begin
            raster_x <= x_wrap ? '0 : raster_x + 1'b1;
            // line advances on pixel wrap
            if (x_wrap) begin
                raster_y <= y_wrap ? '0 : raster_y + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/vdp_reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display register file
// copper write port, host read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module vdp_reg_file import copper_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  reg_wr_t   reg_wr,
    input  reg_addr_t reg_rd_addr,
    output word_t     reg_rd_data
);

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr.en) begin
            regs[reg_wr.addr] <= reg_wr.data;
        end
    end

    // registered host read
    always_ff @(posedge clk) begin
        reg_rd_data <= regs[reg_rd_addr];
    end

endmodule

`default_nettype wire

// File: test/copper_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper testbench
// program load over host credits,
// write log and register checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module copper_tb import copper_pkg::*; ();

    typedef struct packed {
        reg_wr_t   wr;
        logic      has_pos;
        raster_x_t min_x;
        raster_y_t min_y;
    } exp_write_t;

    localparam int write_limit = 3 * raster_w * raster_h;
    localparam int drain_limit = 200;
    localparam int rd_count    = 19;

    logic       clk;
    logic       rst_n;
    logic       enable;
    host_wr_t   host_wr;
    reg_addr_t  reg_rd_addr;
    logic       host_credit;
    reg_wr_t    reg_wr;
    word_t      reg_rd_data;
    raster_x_t  raster_x;
    raster_y_t  raster_y;

    word_t      prog [$];
    exp_write_t expected [$];

    // final register contents after any complete pass
    reg_addr_t rd_reg [rd_count] = '{5'd0, 5'd1, 5'd2, 5'd4, 5'd12, 5'd13, 5'd14, 5'd15,
        5'd16, 5'd17, 5'd18, 5'd19, 5'd20, 5'd22, 5'd23, 5'd24, 5'd25, 5'd30, 5'd31};
    word_t rd_val [rd_count] = '{16'h0000, 16'h0011, 16'h0007, 16'ha001, 16'hc001,
        16'hc002, 16'hc003, 16'hc004, 16'hd009, 16'hd00a, 16'hd00b, 16'hd00c,
        16'he003, 16'he101, 16'he102, 16'hf005, 16'hf006, 16'h0000, 16'h0000};

    int cycle;
    int writes_issued;
    int credits_back;
    int value_errors;
    int protocol_errors;
    int timeouts;
    bit aborted;
    int first_a;
    int first_b;

    copper_top i_copper_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .host_wr     (host_wr),
        .reg_rd_addr (reg_rd_addr),
        .host_credit (host_credit),
        .reg_wr      (reg_wr),
        .reg_rd_data (reg_rd_data),
        .raster_x    (raster_x),
        .raster_y    (raster_y)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // credits come back one per committed host write
    always @(posedge clk) begin
        if (!rst_n) begin
            credits_back <= 0;
        end else if (host_credit) begin
            if (credits_back >= writes_issued) begin
                protocol_errors++;
                $display("credit returned at %0t with no host write outstanding", $time);
            end
            credits_back <= credits_back + 1;
        end
    end

    function automatic word_t target_word(logic wait_en, logic select_y, int value);
        target_fmt_t f;
        f          = '0;
        f.op       = op_set_target;
        f.wait_en  = wait_en;
        f.select_y = select_y;
        f.value    = 11'(value);
        return word_t'(f);
    endfunction

    function automatic word_t write_word(logic [1:0] inc_mode, logic auto_wait, int batches,
                                         int target);
        write_fmt_t f;
        f             = '0;
        f.op          = op_write_reg;
        f.inc_mode    = inc_mode;
        f.auto_wait   = auto_wait;
        f.batch_count = 5'(batches);
        f.target_reg  = reg_addr_t'(target);
        return word_t'(f);
    endfunction

    function automatic word_t compressed_word(logic auto_inc_y, logic [4:0] data, int target);
        compressed_fmt_t f;
        f            = '0;
        f.op         = op_write_compressed;
        f.auto_inc_y = auto_inc_y;
        f.data       = data;
        f.target_reg = 6'(target);
        return word_t'(f);
    endfunction

    function automatic word_t jump_word(int target);
        jump_fmt_t f;
        f        = '0;
        f.op     = op_jump;
        f.target = prog_addr_t'(target);
        return word_t'(f);
    endfunction

    task automatic add_data(word_t first, int n);
        for (int i = 0; i < n; i++) begin
            prog.push_back(first + word_t'(i));
        end
    endtask

    task automatic expect_write(int r, word_t data, logic has_pos, int x, int y);
        exp_write_t e;
        e.wr      = '{en: 1'b1, addr: reg_addr_t'(r), data: data};
        e.has_pos = has_pos;
        e.min_x   = raster_x_t'(x);
        e.min_y   = raster_y_t'(y);
        expected.push_back(e);
    endtask

    // register offset cycles through the batch size
    task automatic expect_batch(int base, int batch_size, int total, word_t first);
        for (int i = 0; i < total; i++) begin
            expect_write(base + (i % batch_size), first + word_t'(i), 1'b0, 0, 0);
        end
    endtask

    task automatic build_tables();
        prog.push_back(target_word(1'b0, 1'b1, 2));
        prog.push_back(target_word(1'b1, 1'b0, 3));
        prog.push_back(compressed_word(1'b1, 5'h11, 1));
        prog.push_back(target_word(1'b1, 1'b0, 4));
        prog.push_back(compressed_word(1'b0, 5'h07, 2));
        prog.push_back(write_word(2'd0, 1'b0, 0, 4));
        add_data(16'ha001, 1);
        prog.push_back(write_word(2'd2, 1'b0, 0, 12));
        add_data(16'hc001, 4);
        prog.push_back(write_word(2'd2, 1'b0, 2, 16));
        add_data(16'hd001, 12);
        prog.push_back(write_word(2'd0, 1'b0, 2, 20));
        add_data(16'he001, 3);
        prog.push_back(write_word(2'd1, 1'b0, 0, 22));
        add_data(16'he101, 2);
        // auto-wait batches on lines 8, 9 and 10
        prog.push_back(target_word(1'b0, 1'b1, 8));
        prog.push_back(target_word(1'b1, 1'b0, 1));
        prog.push_back(write_word(2'd1, 1'b1, 2, 24));
        add_data(16'hf001, 6);
        prog.push_back(jump_word(0));

        expect_write(1, 16'h0011, 1'b1, 3, 2);
        // auto-increment-y moves the next wait one line down
        expect_write(2, 16'h0007, 1'b1, 4, 3);
        expect_batch(4, 1, 1, 16'ha001);
        expect_batch(12, 4, 4, 16'hc001);
        expect_batch(16, 4, 12, 16'hd001);
        expect_batch(20, 1, 3, 16'he001);
        expect_batch(22, 2, 2, 16'he101);
        expect_write(24, 16'hf001, 1'b1, 1, 8);
        expect_write(25, 16'hf002, 1'b1, 1, 8);
        expect_write(24, 16'hf003, 1'b1, 1, 9);
        expect_write(25, 16'hf004, 1'b1, 1, 9);
        expect_write(24, 16'hf005, 1'b1, 1, 10);
        expect_write(25, 16'hf006, 1'b1, 1, 10);
    endtask

    task automatic note_timeout(string what);
        timeouts++;
        aborted = 1'b1;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic check_reg_wr(reg_wr_t got, raster_x_t x, raster_y_t y, exp_write_t exp);
        if (got.addr !== exp.wr.addr || got.data !== exp.wr.data) begin
            value_errors++;
            $display("ERROR %0t: write reg %0d data %h, expected reg %0d data %h",
                     $time, got.addr, got.data, exp.wr.addr, exp.wr.data);
        end else if (exp.has_pos && (y !== exp.min_y || x < exp.min_x)) begin
            value_errors++;
            $display("ERROR %0t: write reg %0d at x %0d line %0d, expected line %0d x >= %0d",
                     $time, got.addr, x, y, exp.min_y, exp.min_x);
        end
    endtask

    task automatic check_reg(reg_addr_t addr, word_t got, word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %0t: register %0d reads %h, expected %h", $time, addr, got, exp);
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        if (got != exp) begin
            value_errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // host loader, one credit per write, random idle gaps
    task automatic load_program();
        int idx;
        int gap;
        int waited;
        idx    = 0;
        gap    = 0;
        waited = 0;
        while (!aborted && idx < prog.size()) begin
            @(posedge clk);
            waited++;
            if (gap > 0 || writes_issued - credits_back >= host_credits) begin
                host_wr <= '0;
                if (gap > 0) begin
                    gap--;
                end
            end else begin
                host_wr <= '{en: 1'b1, addr: prog_addr_t'(idx), data: prog[idx]};
                writes_issued++;
                idx++;
                gap = $urandom_range(3);
            end
            if (waited > 20 * prog.size()) begin
                note_timeout("host credits during program load");
            end
        end
        @(posedge clk);
        host_wr <= '0;
        waited = 0;
        while (!aborted && credits_back != writes_issued) begin
            @(posedge clk);
            waited++;
            if (waited > drain_limit) begin
                note_timeout("credit return for all host writes");
            end
        end
        repeat (8) @(posedge clk);
        check_count("credits held after load", host_credits - writes_issued + credits_back,
                    host_credits);
    endtask

    task automatic next_write(output reg_wr_t wr, output raster_x_t x, output raster_y_t y,
                              output int at_cycle);
        int waited;
        waited   = 0;
        wr       = '0;
        x        = '0;
        y        = '0;
        at_cycle = 0;
        while (!aborted && !wr.en) begin
            @(posedge clk);
            if (reg_wr.en) begin
                wr       = reg_wr;
                x        = raster_x;
                y        = raster_y;
                at_cycle = cycle;
            end else begin
                waited++;
                if (waited > write_limit) begin
                    note_timeout("a register write from the copper");
                end
            end
        end
    endtask

    task automatic run_pass(int count, output int first_cycle);
        reg_wr_t   wr;
        raster_x_t x;
        raster_y_t y;
        int        at;
        first_cycle = 0;
        for (int i = 0; i < count && !aborted; i++) begin
            next_write(wr, x, y, at);
            if (i == 0) begin
                first_cycle = at;
            end
            if (!aborted) begin
                check_reg_wr(wr, x, y, expected[i]);
            end
        end
    endtask

    task automatic check_disabled(int next_index);
        int strobes;
        strobes = 0;
        @(posedge clk);
        // a write decoded on the edge that dropped enable still lands
        if (reg_wr.en) begin
            check_reg_wr(reg_wr, raster_x, raster_y, expected[next_index]);
        end
        repeat (3 * raster_w) begin
            @(posedge clk);
            if (reg_wr.en) begin
                strobes++;
            end
        end
        if (strobes != 0) begin
            protocol_errors++;
            $display("%0d register writes seen while the copper was disabled", strobes);
        end
    endtask

    task automatic check_registers();
        for (int i = 0; i < rd_count && !aborted; i++) begin
            @(posedge clk);
            reg_rd_addr <= rd_reg[i];
            @(posedge clk);
            @(posedge clk);
            check_reg(rd_reg[i], reg_rd_data, rd_val[i]);
        end
    endtask

    initial begin
        void'($urandom(32'hfb373540));
        rst_n       = 1'b0;
        enable      = 1'b0;
        host_wr     = '0;
        reg_rd_addr = '0;
        build_tables();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (reg_wr.en !== 1'b0 || host_credit !== 1'b0) begin
            protocol_errors++;
            $display("control outputs not low after reset");
        end
        load_program();
        @(posedge clk);
        enable <= 1'b1;
        run_pass(expected.size(), first_a);
        run_pass(expected.size(), first_b);
        // the loop restarts at the same raster position each frame
        if (!aborted) begin
            check_count("cycles between passes", first_b - first_a, raster_w * raster_h);
        end
        run_pass(8, first_a);
        enable <= 1'b0;
        if (!aborted) begin
            check_disabled(8);
        end
        enable <= 1'b1;
        run_pass(expected.size(), first_a);
        check_registers();
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/copper_pkg.sv
rtl/raster_timer.sv
rtl/copper.sv
rtl/copper_program_mem.sv
rtl/vdp_reg_file.sv
rtl/copper_top.sv
test/copper_tb.sv
